/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // major opcodes the fetch unit reacts to
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        REGIMM  = 6'h01,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLEZ    = 6'h06,
        BGTZ    = 6'h07
    } opcodeT;

    // SPECIAL function codes for register jumps
    typedef enum logic [5:0] {
        JR   = 6'h08,
        JALR = 6'h09
    } functT;

    typedef enum logic [1:0] {
        SEQ      = 2'd0,
        BRANCH   = 2'd1,
        JUMP_IMM = 2'd2,
        JUMP_REG = 2'd3
    } npcSelT;

    // kernel control from the coprocessor
    typedef enum logic [1:0] {
        NONE = 2'd0,
        TRAP = 2'd1,
        ERET = 2'd2
    } kCtrlT;

    localparam logic [4:0] EXC_NONE = 5'd0;
    // address error on load or fetch
    localparam logic [4:0] EXC_ADEL = 5'd4;

    // APB register map
    localparam logic [11:0] REG_CTRL     = 12'h000;
    localparam logic [11:0] REG_TRAPVEC  = 12'h004;
    localparam logic [11:0] REG_EPC      = 12'h008;
    localparam logic [11:0] REG_BADADDR  = 12'h00C;
    localparam logic [11:0] REG_EXCCOUNT = 12'h010;
    localparam logic [11:0] IMEM_WINDOW  = 12'h800;

endpackage

`default_nettype wire

/* csrIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface csrIf #(
    parameter int imemWords = 256
) ();
    localparam int addrBits = $clog2(imemWords);

    // configuration towards fetch
    logic                fetchEnable;
    logic [31:0]         trapVector;
    logic [31:0]         epc;

    // instruction memory write port
    logic                imemWe;
    logic [addrBits-1:0] imemWaddr;
    logic [31:0]         imemWdata;

    // fault report back to the register block
    logic                excValid;
    logic [31:0]         excAddr;

    modport csr (
        output fetchEnable, trapVector, epc, imemWe, imemWaddr, imemWdata,
        input  excValid, excAddr
    );

    modport stage (
        input  fetchEnable,
        output excValid, excAddr
    );

    modport mem (
        input imemWe, imemWaddr, imemWdata
    );

endinterface

`default_nettype wire

/* fetchCsr.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchCsr #(
    parameter int imemWords = 256
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [11:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    csrIf.csr                cfg
);
    import mipsPkg::*;

    localparam int addrBits = $clog2(imemWords);

    logic        access;
    logic        winHit;
    logic        mapped;
    logic        readOnly;
    logic [31:0] rdata;

    logic        fetchEnable;
    logic [31:0] trapVector;
    logic [31:0] epc;
    logic [31:0] badAddr;
    logic [15:0] excCount;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    // word-aligned hit inside the populated part of the window
    assign winHit = paddr[11] && (paddr[1:0] == 2'b00)
                    && ({23'b0, paddr[10:2]} < 32'(imemWords));

    always_comb begin
        rdata    = '0;
        mapped   = 1'b1;
        readOnly = 1'b0;
        case (paddr)
            REG_CTRL:     rdata = {31'b0, fetchEnable};
            REG_TRAPVEC:  rdata = trapVector;
            REG_EPC:      rdata = epc;
            REG_BADADDR: begin
                rdata    = badAddr;
                readOnly = 1'b1;
            end
            REG_EXCCOUNT: begin
                rdata    = {16'b0, excCount};
                readOnly = 1'b1;
            end
            // reads of the write-only window give zero
            default:      mapped = winHit;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rdata : 32'b0;
    assign pslverr = access && (!mapped || (pwrite && readOnly));

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchEnable <= 1'b0;
            trapVector  <= '0;
            epc         <= '0;
            badAddr     <= '0;
            excCount    <= '0;
        end else begin
            if (access && pwrite) begin
                case (paddr)
                    REG_CTRL:    fetchEnable <= pwdata[0];
                    REG_TRAPVEC: trapVector  <= pwdata;
                    REG_EPC:     epc         <= pwdata;
                    default:     ;
                endcase
            end
            if (cfg.excValid) begin
                badAddr <= cfg.excAddr;
                // saturate at all ones
                if (excCount != 16'hffff) begin
                    excCount <= excCount + 16'd1;
                end
            end
        end
    end

    assign cfg.fetchEnable = fetchEnable;
    assign cfg.trapVector  = trapVector;
    assign cfg.epc         = epc;

    // write strobe lands on the access-phase edge
    assign cfg.imemWe    = access && pwrite && winHit;
    assign cfg.imemWaddr = paddr[addrBits+1:2];
    assign cfg.imemWdata = pwdata;

endmodule

`default_nettype wire

/* nextPc.sv */
`timescale 1ns/1ps
`default_nettype none

module nextPc (
    input  wire logic [31:0]   instr,
    input  wire logic          cmp,
    input  wire logic [31:0]   pcIf,
    input  wire logic [31:0]   jmpReg,
    input  wire mipsPkg::kCtrlT kCtrl,
    input  wire logic [31:0]   epc,
    input  wire logic [31:0]   trapVector,
    output logic      [31:0]   npc,
    output logic               isJump
);
    import mipsPkg::*;

    opcodeT      opcode;
    functT       funct;
    npcSelT      sel;
    logic [15:0] imm16;
    logic [25:0] index;
    logic [31:0] branchOff;
    logic [31:0] pathPc;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign imm16  = instr[15:0];
    assign index  = instr[25:0];

    // sign-extended word offset
    assign branchOff = {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        sel    = SEQ;
        isJump = 1'b0;
        case (opcode)
            SPECIAL: begin
                if (funct == JR || funct == JALR) begin
                    sel    = JUMP_REG;
                    isJump = 1'b1;
                end
            end
            J, JAL: begin
                sel    = JUMP_IMM;
                isJump = 1'b1;
            end
            BEQ, BNE, BLEZ, BGTZ, REGIMM: begin
                // taken only on a true compare
                isJump = 1'b1;
                if (cmp) begin
                    sel = BRANCH;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (sel)
            BRANCH:   pathPc = pcIf + branchOff;
            JUMP_IMM: pathPc = {pcIf[31:28], index, 2'b00};
            JUMP_REG: pathPc = jmpReg;
            default:  pathPc = pcIf + 32'd4;
        endcase
    end

    // kernel redirects win over any branch
    assign npc = (kCtrl == TRAP) ? trapVector :
                 (kCtrl == ERET) ? {epc[31:2], 2'b00} :
                 pathPc;

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter logic [31:0] textBase  = 32'h0000_3000,
    parameter int          imemWords = 256
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stall,
    input  wire logic        clr,
    input  wire logic        stallPc,
    input  wire logic [31:0] npc,
    input  wire logic [31:0] code,
    input  wire logic        isJump,
    output logic      [31:0] pcIf,
    output logic      [31:0] fetchCode,
    output logic      [31:0] fetchPc,
    output logic      [4:0]  fetchExc,
    output logic             fetchBd,
    csrIf.stage              cfg
);
    import mipsPkg::*;

    localparam logic [31:0] memBytes = 32'(imemWords) * 32'd4;

    logic [31:0] offset;
    logic        fault;
    logic        loading;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcIf <= textBase;
        end else if (cfg.fetchEnable && !stallPc) begin
            pcIf <= npc;
        end
    end

    // unsigned offset also catches addresses below the base
    assign offset  = pcIf - textBase;
    assign fault   = (pcIf[1:0] != 2'b00) || (offset >= memBytes);
    assign loading = !stall && !clr;

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            fetchCode <= '0;
            fetchPc   <= '0;
            fetchExc  <= EXC_NONE;
            fetchBd   <= 1'b0;
        end else if (!stall) begin
            fetchCode <= fault ? 32'b0 : code;
            fetchPc   <= pcIf;
            fetchExc  <= fault ? EXC_ADEL : EXC_NONE;
            fetchBd   <= isJump;
        end
    end

    // one report per faulting fetch taken into IF/ID
    assign cfg.excValid = fault && loading;
    assign cfg.excAddr  = pcIf;

endmodule

`default_nettype wire

/* instrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter logic [31:0] textBase  = 32'h0000_3000,
    parameter int          imemWords = 256
) (
    input  wire logic        clk,
    input  wire logic [31:0] pcIf,
    output logic      [31:0] code,
    csrIf.mem                wr
);
    localparam int          addrBits = $clog2(imemWords);
    localparam logic [31:0] memBytes = 32'(imemWords) * 32'd4;

    logic [31:0]         mem [imemWords];
    logic [31:0]         offset;
    logic [addrBits-1:0] index;

    // relocate to the text base
    assign offset = pcIf - textBase;
    assign index  = offset[addrBits+1:2];
    assign code   = (offset < memBytes) ? mem[index] : 32'b0;

    // loaded only through the APB window
    always_ff @(posedge clk) begin
        if (wr.imemWe) begin
            mem[wr.imemWaddr] <= wr.imemWdata;
        end
    end

endmodule

`default_nettype wire

/* fetchTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTop #(
    parameter logic [31:0] textBase  = 32'h0000_3000,
    parameter int          imemWords = 256
) (
    input  wire logic           clk,
    input  wire logic           reset,
    // APB
    input  wire logic [11:0]    paddr,
    input  wire logic           psel,
    input  wire logic           penable,
    input  wire logic           pwrite,
    input  wire logic [31:0]    pwdata,
    output logic      [31:0]    prdata,
    output logic                pready,
    output logic                pslverr,
    // pipeline control
    input  wire logic           stall,
    input  wire logic           clr,
    input  wire logic           stallPc,
    // from decode
    input  wire logic [31:0]    instr,
    input  wire logic           cmp,
    input  wire logic [31:0]    jmpReg,
    input  wire mipsPkg::kCtrlT kCtrl,
    // IF/ID
    output logic      [31:0]    pcIf,
    output logic      [31:0]    fetchCode,
    output logic      [31:0]    fetchPc,
    output logic      [4:0]     fetchExc,
    output logic                fetchBd
);
    logic [31:0] npc;
    logic [31:0] code;
    logic        isJump;

    csrIf #(.imemWords(imemWords)) cfg ();

    fetchCsr #(
        .imemWords (imemWords)
    ) fetchCsr_inst (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg.csr)
    );

    // redirect targets come straight from the register block
    nextPc nextPc_inst (
        .instr      (instr),
        .cmp        (cmp),
        .pcIf       (pcIf),
        .jmpReg     (jmpReg),
        .kCtrl      (kCtrl),
        .epc        (cfg.epc),
        .trapVector (cfg.trapVector),
        .npc        (npc),
        .isJump     (isJump)
    );

    fetchStage #(
        .textBase  (textBase),
        .imemWords (imemWords)
    ) fetchStage_inst (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .clr       (clr),
        .stallPc   (stallPc),
        .npc       (npc),
        .code      (code),
        .isJump    (isJump),
        .pcIf      (pcIf),
        .fetchCode (fetchCode),
        .fetchPc   (fetchPc),
        .fetchExc  (fetchExc),
        .fetchBd   (fetchBd),
        .cfg       (cfg.stage)
    );

    instrMem #(
        .textBase  (textBase),
        .imemWords (imemWords)
    ) instrMem_inst (
        .clk  (clk),
        .pcIf (pcIf),
        .code (code),
        .wr   (cfg.mem)
    );

endmodule

`default_nettype wire

/* fetchTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTb;
    import mipsPkg::*;

    localparam logic [31:0] textBase  = 32'h0000_3000;
    localparam int          imemWords = 256;
    localparam int          addrBits  = $clog2(imemWords);
    // roughly twice the summed length of all phases
    localparam int          maxCycles = 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        stall;
    logic        clr;
    logic        stallPc;
    logic [31:0] instr;
    logic        cmp;
    logic [31:0] jmpReg;
    kCtrlT       kCtrl;
    logic [31:0] pcIf;
    logic [31:0] fetchCode;
    logic [31:0] fetchPc;
    logic [4:0]  fetchExc;
    logic        fetchBd;

    // model state updated on rising edges
    logic [31:0] lfsr = 32'hff73;
    logic [31:0] memCopy [imemWords];
    logic        memKnown [imemWords];
    logic [31:0] expPc;
    logic [31:0] expCode;
    logic        expCodeValid;
    logic [31:0] expFetchPc;
    logic [4:0]  expExc;
    logic        expBd;
    logic        shadowEnable;
    logic [31:0] shadowTrap;
    logic [31:0] shadowEpc;
    int          cycleCount = 0;

    fetchTop #(
        .textBase  (textBase),
        .imemWords (imemWords)
    ) fetchTop_inst (.*);

    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // fibonacci taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // aligned address inside instruction memory
    function automatic logic [31:0] randTarget();
        logic [31:0] r;
        r = randBits(addrBits);
        return textBase + (r << 2);
    endfunction

    function automatic logic isControlFlow(input logic [31:0] ins);
        logic [5:0] op;
        op = ins[31:26];
        if (op == SPECIAL) begin
            return (ins[5:0] == JR) || (ins[5:0] == JALR);
        end
        return (op == J) || (op == JAL) || (op == BEQ) || (op == BNE)
               || (op == BLEZ) || (op == BGTZ) || (op == REGIMM);
    endfunction

    function automatic logic [31:0] modelNextPc(input logic [31:0] pc, input logic [31:0] ins,
                                                input logic c, input logic [31:0] jr,
                                                input kCtrlT k, input logic [31:0] ep,
                                                input logic [31:0] tv);
        logic [5:0]  op;
        logic [31:0] off;
        op  = ins[31:26];
        off = {{14{ins[15]}}, ins[15:0], 2'b00};
        if (k == TRAP) begin
            return tv;
        end
        if (k == ERET) begin
            return ep & 32'hffff_fffc;
        end
        if (op == SPECIAL && (ins[5:0] == JR || ins[5:0] == JALR)) begin
            return jr;
        end
        if (op == J || op == JAL) begin
            return {pc[31:28], ins[25:0], 2'b00};
        end
        if (isControlFlow(ins) && c) begin
            return pc + off;
        end
        return pc + 32'd4;
    endfunction

    task automatic setDecode(input logic [31:0] ins, input logic c, input logic [31:0] jr,
                             input kCtrlT k);
        instr  = ins;
        cmp    = c;
        jmpReg = jr;
        kCtrl  = k;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                            input logic expErr);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        checkValue("pready", 32'(pready), 32'd1);
        checkValue("pslverr", 32'(pslverr), 32'(expErr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic expErr,
                           output logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        checkValue("pready", 32'(pready), 32'd1);
        checkValue("pslverr", 32'(pslverr), 32'(expErr));
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // compare pre-edge outputs, then advance the model
    always @(posedge clk) begin : compare
        logic [31:0] offs;
        logic        fault;
        cycleCount = cycleCount + 1;
        if (cycleCount > maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end else if (reset) begin
            expPc        = textBase;
            expCode      = '0;
            expCodeValid = 1'b1;
            expFetchPc   = '0;
            expExc       = EXC_NONE;
            expBd        = 1'b0;
            shadowEnable = 1'b0;
            shadowTrap   = '0;
            shadowEpc    = '0;
        end else begin
            checkValue("pcIf", pcIf, expPc);
            if (expCodeValid) begin
                checkValue("fetchCode", fetchCode, expCode);
            end
            checkValue("fetchPc", fetchPc, expFetchPc);
            checkValue("fetchExc", 32'(fetchExc), 32'(expExc));
            checkValue("fetchBd", 32'(fetchBd), 32'(expBd));

            offs  = expPc - textBase;
            fault = (expPc[1:0] != 2'b00) || (offs >= 32'(imemWords * 4));
            if (clr) begin
                expCode      = '0;
                expCodeValid = 1'b1;
                expFetchPc   = '0;
                expExc       = EXC_NONE;
                expBd        = 1'b0;
            end else if (!stall) begin
                expCode      = fault ? 32'b0 : memCopy[offs[addrBits+1:2]];
                expCodeValid = fault || memKnown[offs[addrBits+1:2]];
                expFetchPc   = expPc;
                expExc       = fault ? EXC_ADEL : EXC_NONE;
                expBd        = isControlFlow(instr);
            end
            if (shadowEnable && !stallPc) begin
                expPc = modelNextPc(expPc, instr, cmp, jmpReg, kCtrl, shadowEpc, shadowTrap);
            end

            // track register and memory writes committed on this edge
            if (psel && penable && pwrite) begin
                if (paddr == REG_CTRL) shadowEnable = pwdata[0];
                if (paddr == REG_TRAPVEC) shadowTrap = pwdata;
                if (paddr == REG_EPC) shadowEpc = pwdata;
                if (paddr[11] && paddr[1:0] == 2'b00 && int'(paddr[10:2]) < imemWords) begin
                    memCopy[paddr[addrBits+1:2]]  = pwdata;
                    memKnown[paddr[addrBits+1:2]] = 1'b1;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] countBefore;
        logic [31:0] target;
        logic [31:0] diff;
        logic [31:0] fields;
        logic [31:0] ins;
        logic [2:0]  kind;
        logic [31:0] trapT;
        logic [31:0] epcT;
        logic [31:0] badMis;
        logic [31:0] badRange;
        logic [31:0] nopIns;
        logic [31:0] jrIns;
        for (int i = 0; i < imemWords; i++) begin
            memKnown[i] = 1'b0;
            memCopy[i]  = '0;
        end
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        stall   = 1'b0;
        clr     = 1'b0;
        stallPc = 1'b0;
        nopIns  = 32'h0000_0000;
        jrIns   = {6'h00, 5'd7, 15'b0, JR};
        setDecode(nopIns, 1'b0, '0, NONE);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // register access while fetch is still disabled
        apbWrite(REG_TRAPVEC, 32'h1234_5678, 1'b0);
        apbRead(REG_TRAPVEC, 1'b0, data);
        checkValue("TRAPVEC", data, 32'h1234_5678);
        apbWrite(REG_EPC, 32'hcafe_0001, 1'b0);
        apbRead(REG_EPC, 1'b0, data);
        checkValue("EPC", data, 32'hcafe_0001);
        apbWrite(REG_CTRL, 32'hffff_fffe, 1'b0);
        apbRead(REG_CTRL, 1'b0, data);
        checkValue("CTRL", data, 32'h0);
        apbWrite(REG_BADADDR, 32'hdead_beef, 1'b1);
        apbWrite(REG_EXCCOUNT, 32'h0000_0005, 1'b1);
        apbRead(REG_BADADDR, 1'b0, data);
        checkValue("BADADDR", data, 32'h0);
        apbRead(REG_EXCCOUNT, 1'b0, data);
        checkValue("EXCCOUNT", data, 32'h0);
        apbRead(12'h014, 1'b1, data);
        apbWrite(12'h100, 32'h1, 1'b1);
        apbWrite(12'hC00, 32'h1, 1'b1);
        apbRead(IMEM_WINDOW, 1'b0, data);
        checkValue("window read", data, 32'h0);

        // fill all of memory, then sequential fetch
        for (int w = 0; w < imemWords; w++) begin
            apbWrite(IMEM_WINDOW + 12'(w * 4), randBits(32), 1'b0);
        end
        setDecode({6'h09, 26'h0}, 1'b0, '0, NONE);
        apbWrite(REG_CTRL, 32'h1, 1'b0);
        repeat (64) begin
            @(negedge clk);
            fields = randBits(32);
            setDecode({6'h09, fields[25:0]}, fields[31], randBits(32), NONE);
        end

        // branches and jumps to aligned targets in range
        repeat (48) begin
            @(negedge clk);
            kind   = 3'(randBits(3));
            target = randTarget();
            fields = randBits(26);
            diff   = target - expPc;
            case (kind)
                3'd0: ins = {BEQ, fields[25:16], diff[17:2]};
                3'd1: ins = {BNE, fields[25:16], diff[17:2]};
                3'd2: ins = {REGIMM, fields[25:16], diff[17:2]};
                3'd3: ins = {BGTZ, fields[25:16], diff[17:2]};
                3'd4: ins = {J, target[27:2]};
                3'd5: ins = {JAL, target[27:2]};
                3'd6: ins = {6'h00, fields[25:21], 15'b0, JR};
                default: ins = {6'h00, fields[25:21], 5'b0, 5'd31, 5'b0, JALR};
            endcase
            setDecode(ins, fields[0], target, NONE);
        end

        // kernel redirects beat a taken branch
        @(negedge clk);
        setDecode(nopIns, 1'b0, '0, NONE);
        trapT = randTarget();
        epcT  = randTarget() + 32'd1 + randBits(1);
        apbWrite(REG_TRAPVEC, trapT, 1'b0);
        apbWrite(REG_EPC, epcT, 1'b0);
        @(negedge clk);
        setDecode({BEQ, 10'h0, 16'h0010}, 1'b1, '0, TRAP);
        @(negedge clk);
        checkValue("pcIf after TRAP", pcIf, trapT);
        setDecode({J, 26'h0000_c40}, 1'b0, '0, ERET);
        @(negedge clk);
        checkValue("pcIf after ERET", pcIf, epcT & 32'hffff_fffc);
        setDecode(nopIns, 1'b0, '0, NONE);

        // stall, stallPc and clr
        @(negedge clk);
        stall = 1'b1;
        repeat (3) @(negedge clk);
        stallPc = 1'b1;
        repeat (3) @(negedge clk);
        stall = 1'b0;
        repeat (3) @(negedge clk);
        stallPc = 1'b0;
        stall   = 1'b1;
        clr     = 1'b1;
        @(negedge clk);
        checkValue("fetchCode under clr", fetchCode, 32'h0);
        checkValue("fetchPc under clr", fetchPc, 32'h0);
        clr   = 1'b0;
        stall = 1'b0;

        // address errors through register jumps
        @(negedge clk);
        setDecode(jrIns, 1'b0, textBase, NONE);
        @(negedge clk);
        setDecode(nopIns, 1'b0, '0, NONE);
        apbRead(REG_EXCCOUNT, 1'b0, countBefore);
        badMis   = randTarget() + 32'd2;
        badRange = textBase + 32'(imemWords * 4) + randTarget();
        @(negedge clk);
        setDecode(jrIns, 1'b0, badMis, NONE);
        @(negedge clk);
        setDecode(jrIns, 1'b0, badRange, NONE);
        @(negedge clk);
        checkValue("fetchExc misaligned", 32'(fetchExc), 32'(EXC_ADEL));
        checkValue("fetchCode misaligned", fetchCode, 32'h0);
        checkValue("fetchPc misaligned", fetchPc, badMis);
        setDecode(jrIns, 1'b0, textBase, NONE);
        @(negedge clk);
        checkValue("fetchExc out of range", 32'(fetchExc), 32'(EXC_ADEL));
        checkValue("fetchPc out of range", fetchPc, badRange);
        setDecode(nopIns, 1'b0, '0, NONE);
        apbRead(REG_BADADDR, 1'b0, data);
        checkValue("BADADDR", data, badRange);
        apbRead(REG_EXCCOUNT, 1'b0, data);
        checkValue("EXCCOUNT", data, countBefore + 32'd2);

        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
mipsPkg.sv
csrIf.sv
fetchCsr.sv
nextPc.sv
fetchStage.sv
instrMem.sv
fetchTop.sv
fetchTb.sv

/* Makefile */
# Verilator build for the fetch stage and its testbench

VERILATOR ?= verilator
TOP       ?= fetchTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	-./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
